//--- verilog/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // datapath and instruction width
  localparam int XLEN = 32;
  // register index width
  localparam int REG_AW = 5;

  // major opcodes the pipeline executes
  typedef enum logic [6:0] {
    OP_REG   = 7'b0110011,
    OP_IMM   = 7'b0010011,
    OP_LUI   = 7'b0110111,
    OP_AUIPC = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_e;

  // operand a source
  typedef enum logic {RS1, PC} opa_sel_e;

  // operand b source
  typedef enum logic {RS2, IMM} opb_sel_e;

  // where an ex source register value comes from
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_MEM  = 2'b01,
    FWD_WB   = 2'b10
  } fwd_sel_e;

endpackage

//--- verilog/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  logic [rv_pipe_pkg::XLEN-1:0] i_instr,
  output logic                         o_insn_vld,
  output logic                         o_rd_wren,
  output rv_pipe_pkg::opa_sel_e        o_opa_sel,
  output rv_pipe_pkg::opb_sel_e        o_opb_sel,
  output rv_pipe_pkg::alu_op_e         o_alu_op,
  output logic [rv_pipe_pkg::XLEN-1:0] o_imm
);
  import rv_pipe_pkg::*;

  opcode_e           opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rd;
  logic              alt;
  logic              f7_ok;
  alu_op_e           f3_op;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_u;

  assign opcode = opcode_e'(i_instr[6:0]);
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  // funct7 = 0100000 selects sub / sra
  assign alt    = (funct7 == 7'b0100000);

  assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {i_instr[31:12], 12'b0};

  // operation from funct3
  always_comb begin
    case (funct3)
      3'b000:  f3_op = (opcode == OP_REG && alt) ? SUB : ADD;
      3'b001:  f3_op = SLL;
      3'b010:  f3_op = SLT;
      3'b011:  f3_op = SLTU;
      3'b100:  f3_op = XOR;
      3'b101:  f3_op = alt ? SRA : SRL;
      3'b110:  f3_op = OR;
      default: f3_op = AND;
    endcase
  end

  // reject reserved funct7 encodings
  always_comb begin
    if (opcode == OP_REG) begin
      f7_ok = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
    end else if (funct3 == 3'b001) begin
      f7_ok = (funct7 == 7'b0);
    end else if (funct3 == 3'b101) begin
      f7_ok = (funct7 == 7'b0) || alt;
    end else begin
      f7_ok = 1'b1;
    end
  end

  always_comb begin
    o_insn_vld = 1'b0;
    o_opa_sel  = RS1;
    o_opb_sel  = RS2;
    o_alu_op   = ADD;
    o_imm      = imm_i;
    case (opcode)
      OP_REG: begin
        o_insn_vld = f7_ok;
        o_alu_op   = f3_op;
      end
      OP_IMM: begin
        o_insn_vld = f7_ok;
        o_opb_sel  = IMM;
        o_alu_op   = f3_op;
      end
      OP_LUI: begin
        o_insn_vld = 1'b1;
        o_opb_sel  = IMM;
        o_alu_op   = PASS_B;
        o_imm      = imm_u;
      end
      OP_AUIPC: begin
        o_insn_vld = 1'b1;
        o_opa_sel  = PC;
        o_opb_sel  = IMM;
        o_imm      = imm_u;
      end
      default: ;
    endcase
  end

  // x0 is never written
  assign o_rd_wren = o_insn_vld && (rd != '0);

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_rd_wren,
  input  logic [rv_pipe_pkg::REG_AW-1:0] i_rd_addr,
  input  logic [rv_pipe_pkg::XLEN-1:0]   i_rd_data,
  input  logic [rv_pipe_pkg::REG_AW-1:0] i_rs1_addr,
  input  logic [rv_pipe_pkg::REG_AW-1:0] i_rs2_addr,
  output logic [rv_pipe_pkg::XLEN-1:0]   o_rs1_data,
  output logic [rv_pipe_pkg::XLEN-1:0]   o_rs2_data
);
  import rv_pipe_pkg::*;

  // storage for x1..x31 only
  logic [XLEN-1:0] regs [1:2**REG_AW-1];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wren && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // write-through so ID sees the value WB writes this cycle
  function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
    if (addr == '0) return '0;
    if (i_rd_wren && addr == i_rd_addr) return i_rd_data;
    return regs[addr];
  endfunction

  always_comb o_rs1_data = read_port(i_rs1_addr);
  always_comb o_rs2_data = read_port(i_rs2_addr);

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  logic [rv_pipe_pkg::XLEN-1:0] i_pc,
  input  logic [rv_pipe_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_pipe_pkg::XLEN-1:0] i_rs2_data,
  input  logic [rv_pipe_pkg::XLEN-1:0] i_imm,
  input  logic [rv_pipe_pkg::XLEN-1:0] i_mem_data,
  input  logic [rv_pipe_pkg::XLEN-1:0] i_wb_data,
  input  rv_pipe_pkg::fwd_sel_e        i_fwd_a,
  input  rv_pipe_pkg::fwd_sel_e        i_fwd_b,
  input  rv_pipe_pkg::opa_sel_e        i_opa_sel,
  input  rv_pipe_pkg::opb_sel_e        i_opb_sel,
  input  rv_pipe_pkg::alu_op_e         i_alu_op,
  output logic [rv_pipe_pkg::XLEN-1:0] o_alu_data
);
  import rv_pipe_pkg::*;

  logic [XLEN-1:0]         rs1_val;
  logic [XLEN-1:0]         rs2_val;
  logic [XLEN-1:0]         opa;
  logic [XLEN-1:0]         opb;
  logic [$clog2(XLEN)-1:0] shamt;

  function automatic logic [XLEN-1:0] fwd_mux(
    input fwd_sel_e        sel,
    input logic [XLEN-1:0] reg_val,
    input logic [XLEN-1:0] mem_val,
    input logic [XLEN-1:0] wb_val
  );
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign rs1_val = fwd_mux(i_fwd_a, i_rs1_data, i_mem_data, i_wb_data);
  assign rs2_val = fwd_mux(i_fwd_b, i_rs2_data, i_mem_data, i_wb_data);

  assign opa   = (i_opa_sel == PC)  ? i_pc  : rs1_val;
  assign opb   = (i_opb_sel == IMM) ? i_imm : rs2_val;
  // only the low bits count as shift amount
  assign shamt = opb[$clog2(XLEN)-1:0];

  always_comb begin
    case (i_alu_op)
      SUB:     o_alu_data = opa - opb;
      SLL:     o_alu_data = opa << shamt;
      SLT:     o_alu_data = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
      SLTU:    o_alu_data = {{(XLEN-1){1'b0}}, opa < opb};
      XOR:     o_alu_data = opa ^ opb;
      SRL:     o_alu_data = opa >> shamt;
      SRA:     o_alu_data = $unsigned($signed(opa) >>> shamt);
      OR:      o_alu_data = opa | opb;
      AND:     o_alu_data = opa & opb;
      PASS_B:  o_alu_data = opb;
      default: o_alu_data = opa + opb;
    endcase
  end

endmodule

//--- verilog/rv_forward_unit.sv
`timescale 1ns/100ps

module rv_forward_unit (
  input  logic [rv_pipe_pkg::REG_AW-1:0] i_ex_rs1,
  input  logic [rv_pipe_pkg::REG_AW-1:0] i_ex_rs2,
  input  logic [rv_pipe_pkg::REG_AW-1:0] i_mem_rd,
  input  logic                           i_mem_rd_wren,
  input  logic [rv_pipe_pkg::REG_AW-1:0] i_wb_rd,
  input  logic                           i_wb_rd_wren,
  output rv_pipe_pkg::fwd_sel_e          o_fwd_a,
  output rv_pipe_pkg::fwd_sel_e          o_fwd_b
);
  import rv_pipe_pkg::*;

  // the younger producer in MEM wins over WB
  function automatic fwd_sel_e pick(input logic [REG_AW-1:0] rs);
    if (rs == '0) return FWD_NONE;
    if (i_mem_rd_wren && i_mem_rd == rs) return FWD_MEM;
    if (i_wb_rd_wren && i_wb_rd == rs) return FWD_WB;
    return FWD_NONE;
  endfunction

  always_comb o_fwd_a = pick(i_ex_rs1);
  always_comb o_fwd_b = pick(i_ex_rs2);

endmodule

//--- verilog/rv_pipe.sv
`timescale 1ns/100ps

module rv_pipe (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_instr_vld,
  input  logic [rv_pipe_pkg::XLEN-1:0]   i_instr,
  input  logic [rv_pipe_pkg::XLEN-1:0]   i_pc,
  output logic                           o_wb_vld,
  output logic [rv_pipe_pkg::REG_AW-1:0] o_wb_addr,
  output logic [rv_pipe_pkg::XLEN-1:0]   o_wb_data
);
  import rv_pipe_pkg::*;

  // IF_ID
  logic            vld_id;
  logic [XLEN-1:0] pc_id;
  logic [XLEN-1:0] instr_id;
  // ID stage
  logic            insn_vld_id;
  logic            rd_wren_id;
  opa_sel_e        opa_sel_id;
  opb_sel_e        opb_sel_id;
  alu_op_e         alu_op_id;
  logic [XLEN-1:0] imm_id;
  logic [XLEN-1:0] rs1_data_id;
  logic [XLEN-1:0] rs2_data_id;
  // ID_EX
  logic            vld_ex;
  logic [XLEN-1:0] pc_ex;
  logic [XLEN-1:0] instr_ex;
  logic            rd_wren_ex;
  opa_sel_e        opa_sel_ex;
  opb_sel_e        opb_sel_ex;
  alu_op_e         alu_op_ex;
  logic [XLEN-1:0] imm_ex;
  logic [XLEN-1:0] rs1_data_ex;
  logic [XLEN-1:0] rs2_data_ex;
  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  logic [XLEN-1:0] alu_data_ex;
  // EX_MEM
  logic            vld_mem;
  logic [XLEN-1:0] instr_mem;
  logic            rd_wren_mem;
  logic [XLEN-1:0] alu_data_mem;
  logic            mem_wren;
  // MEM_WB
  logic            vld_wb;
  logic [XLEN-1:0] instr_wb;
  logic            rd_wren_wb;
  logic [XLEN-1:0] alu_data_wb;
  logic            wb_wren;
  logic [XLEN-1:0] wb_data;

  // stage valid bits
  // an unsupported opcode leaves a bubble behind ID
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      vld_id  <= 1'b0;
      vld_ex  <= 1'b0;
      vld_mem <= 1'b0;
      vld_wb  <= 1'b0;
    end else begin
      vld_id  <= i_instr_vld;
      vld_ex  <= vld_id & insn_vld_id;
      vld_mem <= vld_ex;
      vld_wb  <= vld_mem;
    end
  end

  always_ff @(posedge i_clk) begin
    pc_id        <= i_pc;
    instr_id     <= i_instr;
    pc_ex        <= pc_id;
    instr_ex     <= instr_id;
    rd_wren_ex   <= rd_wren_id;
    opa_sel_ex   <= opa_sel_id;
    opb_sel_ex   <= opb_sel_id;
    alu_op_ex    <= alu_op_id;
    imm_ex       <= imm_id;
    rs1_data_ex  <= rs1_data_id;
    rs2_data_ex  <= rs2_data_id;
    instr_mem    <= instr_ex;
    rd_wren_mem  <= rd_wren_ex;
    alu_data_mem <= alu_data_ex;
    instr_wb     <= instr_mem;
    rd_wren_wb   <= rd_wren_mem;
    alu_data_wb  <= alu_data_mem;
  end

  rv_decoder u_decoder (
    .i_instr    (instr_id),
    .o_insn_vld (insn_vld_id),
    .o_rd_wren  (rd_wren_id),
    .o_opa_sel  (opa_sel_id),
    .o_opb_sel  (opb_sel_id),
    .o_alu_op   (alu_op_id),
    .o_imm      (imm_id)
  );

  rv_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rd_wren  (wb_wren),
    .i_rd_addr  (instr_wb[11:7]),
    .i_rd_data  (wb_data),
    .i_rs1_addr (instr_id[19:15]),
    .i_rs2_addr (instr_id[24:20]),
    .o_rs1_data (rs1_data_id),
    .o_rs2_data (rs2_data_id)
  );

  assign mem_wren = vld_mem & rd_wren_mem;
  assign wb_wren  = vld_wb & rd_wren_wb;

  rv_forward_unit u_forward (
    .i_ex_rs1      (instr_ex[19:15]),
    .i_ex_rs2      (instr_ex[24:20]),
    .i_mem_rd      (instr_mem[11:7]),
    .i_mem_rd_wren (mem_wren),
    .i_wb_rd       (instr_wb[11:7]),
    .i_wb_rd_wren  (wb_wren),
    .o_fwd_a       (fwd_a),
    .o_fwd_b       (fwd_b)
  );

  rv_alu u_alu (
    .i_pc       (pc_ex),
    .i_rs1_data (rs1_data_ex),
    .i_rs2_data (rs2_data_ex),
    .i_imm      (imm_ex),
    .i_mem_data (alu_data_mem),
    .i_wb_data  (wb_data),
    .i_fwd_a    (fwd_a),
    .i_fwd_b    (fwd_b),
    .i_opa_sel  (opa_sel_ex),
    .i_opb_sel  (opb_sel_ex),
    .i_alu_op   (alu_op_ex),
    .o_alu_data (alu_data_ex)
  );

  // every supported class writes the alu result
  assign wb_data = alu_data_wb;

  assign o_wb_vld  = wb_wren;
  assign o_wb_addr = instr_wb[11:7];
  assign o_wb_data = wb_data;

endmodule

//--- verification/rv_pipe_props.sv
`timescale 1ns/100ps

module rv_pipe_props (
  input logic                           i_clk,
  input logic                           i_rst_n,
  input logic                           o_wb_vld,
  input logic [rv_pipe_pkg::REG_AW-1:0] o_wb_addr,
  input logic [rv_pipe_pkg::XLEN-1:0]   o_wb_data
);

  // number of failed assertions
  int fail_count = 0;

  // x0 writes never retire
  retire_addr_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_vld |-> (o_wb_addr != '0))
    else begin
      fail_count++;
      $error("retire reported a write to x0");
    end

  retire_data_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_vld |-> !$isunknown(o_wb_data))
    else begin
      fail_count++;
      $error("retire data holds unknown bits");
    end

  // all stage valid bits are cleared by reset
  idle_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_wb_vld)
    else begin
      fail_count++;
      $error("retire strobe high in the cycle after reset");
    end

endmodule

bind rv_pipe rv_pipe_props u_props (
  .i_clk     (i_clk),
  .i_rst_n   (i_rst_n),
  .o_wb_vld  (o_wb_vld),
  .o_wb_addr (o_wb_addr),
  .o_wb_data (o_wb_data)
);

//--- verification/rv_pipe_tb.sv
`timescale 1ns/100ps

module rv_pipe_tb;
  import rv_pipe_pkg::*;

  localparam string GOLDEN_FILE    = "verification/rv_pipe_golden.txt";
  localparam int    PASSES         = 2;
  localparam int    RETIRE_TIMEOUT = 50;
  localparam int    QUIET_CYCLES   = 20;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_instr_vld;
  logic [XLEN-1:0]   i_instr;
  logic [XLEN-1:0]   i_pc;
  logic              o_wb_vld;
  logic [REG_AW-1:0] o_wb_addr;
  logic [XLEN-1:0]   o_wb_data;

  int                errors;
  int                seed_val;
  bit                timed_out;
  // instruction stream and expected retires from the golden file
  logic [XLEN-1:0]   in_pc[$];
  logic [XLEN-1:0]   in_instr[$];
  string             exp_name[$];
  logic [REG_AW-1:0] exp_addr[$];
  logic [XLEN-1:0]   exp_data[$];

  rv_pipe uut (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_instr_vld (i_instr_vld),
    .i_instr     (i_instr),
    .i_pc        (i_pc),
    .o_wb_vld    (o_wb_vld),
    .o_wb_addr   (o_wb_addr),
    .o_wb_data   (o_wb_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic check_addr(input string name, input logic [REG_AW-1:0] exp_val,
                            input logic [REG_AW-1:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("Fail %s: expected rd x%0d, actual rd x%0d", name, exp_val, act_val);
    end
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("Fail %s: expected data %08h, actual data %08h", name, exp_val, act_val);
    end
  endtask

  // reads I <pc> <instr> and E <name> <rd> <data> lines and skips # lines
  task automatic load_golden();
    int                fd;
    int                code;
    int                fields;
    int                ch;
    int                guard;
    string             tag;
    string             name;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   word;
    logic [REG_AW-1:0] addr;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("could not open %s", GOLDEN_FILE);
      return;
    end
    guard = 0;
    code = $fscanf(fd, "%s", tag);
    while (code == 1 && guard < 1000) begin
      if (tag == "#") begin
        do begin
          ch = $fgetc(fd);
        end while (ch != 10 && ch != -1);
      end else if (tag == "I") begin
        fields = $fscanf(fd, "%h %h", pc, word);
        if (fields != 2) begin
          errors++;
          $display("malformed instruction line in %s", GOLDEN_FILE);
        end
        in_pc.push_back(pc);
        in_instr.push_back(word);
      end else if (tag == "E") begin
        fields = $fscanf(fd, "%s %h %h", name, addr, word);
        if (fields != 3) begin
          errors++;
          $display("malformed expected line in %s", GOLDEN_FILE);
        end
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(word);
      end else begin
        errors++;
        $display("unknown line tag %s in %s", tag, GOLDEN_FILE);
      end
      guard++;
      code = $fscanf(fd, "%s", tag);
    end
    $fclose(fd);
    if (in_instr.size() == 0 || exp_addr.size() == 0) begin
      errors++;
      $display("golden file holds no instructions or no expected retires");
    end
  endtask

  // back-to-back on the first pass, random idle gaps on the second
  task automatic drive_stream();
    int gap;
    for (int p = 0; p < PASSES; p++) begin
      for (int i = 0; i < in_instr.size(); i++) begin
        gap = (p == 0) ? 0 : $urandom_range(3, 0);
        @(posedge i_clk);
        #1;
        i_instr_vld = 1'b1;
        i_instr     = in_instr[i];
        i_pc        = in_pc[i];
        repeat (gap) begin
          @(posedge i_clk);
          #1;
          i_instr_vld = 1'b0;
        end
      end
    end
    @(posedge i_clk);
    #1;
    i_instr_vld = 1'b0;
  endtask

  // retire outputs are sampled mid-cycle
  task automatic check_retires();
    int wait_cnt;
    for (int p = 0; p < PASSES; p++) begin
      for (int k = 0; k < exp_addr.size(); k++) begin
        wait_cnt = 0;
        do begin
          @(negedge i_clk);
          wait_cnt++;
        end while (o_wb_vld !== 1'b1 && wait_cnt < RETIRE_TIMEOUT);
        if (o_wb_vld !== 1'b1) begin
          errors++;
          timed_out = 1'b1;
          $display("no retire arrived within %0d cycles for %s", RETIRE_TIMEOUT, exp_name[k]);
          return;
        end
        check_addr(exp_name[k], exp_addr[k], o_wb_addr);
        check_data(exp_name[k], exp_data[k], o_wb_data);
      end
    end
  endtask

  task automatic check_quiet();
    repeat (QUIET_CYCLES) begin
      @(negedge i_clk);
      if (o_wb_vld !== 1'b0) begin
        errors++;
        $display("unexpected retire to x%0d after the last expected entry", o_wb_addr);
      end
    end
  endtask

  initial begin
    errors      = 0;
    timed_out   = 1'b0;
    i_rst_n     = 1'b0;
    i_instr_vld = 1'b0;
    i_instr     = '0;
    i_pc        = '0;
    seed_val    = $urandom(7);
    load_golden();
    repeat (3) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    fork
      drive_stream();
      check_retires();
    join
    if (!timed_out) begin
      check_quiet();
    end
    $display("retire checks finished with %0d error(s) and %0d assertion failure(s)",
             errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verification/rv_pipe_golden.txt
# I <pc hex> <instruction hex> : fed to the pipeline in this order
# E <test name> <rd hex> <data hex> : expected register writes in retire order
I 00000000 00500093
I 00000004 ff800113
I 00000008 7ff04193
I 0000000c fff00213
I 00000010 00102293
I 00000014 40215313
I 00000018 ff912393
I 0000001c 0f024413
I 00000020 003084b3
I 00000024 40148533
I 00000028 009515b3
I 0000002c 0025b633
I 00000030 00b666b3
I 00000034 00b6f733
I 00000038 123457b7
I 0000003c 00001817
I 00000040 fffff897
I 00000044 05508013
I 00000048 00100ab3
I 0000004c 00002903
I 00000050 021089b3
I 00000054 00000a6f
I 00000058 01396b33
I 0000005c 000a0bb3
E opimm_addi_pos 01 00000005
E opimm_addi_neg 02 fffffff8
E opimm_xori 03 000007ff
E opimm_addi_ones 04 ffffffff
E opimm_slti_zero 05 00000001
E opimm_srai 06 fffffffe
E opimm_slti_neg 07 00000001
E opimm_xori_reg 08 ffffff0f
E fwd_add 09 00000804
E fwd_sub_mem 0a 000007ff
E fwd_sll_mem_wb 0b 00007ff0
E fwd_sltu_mem 0c 00000001
E fwd_or_mem_wb 0d 00007ff1
E fwd_and_write_through 0e 00007ff0
E upper_lui 0f 12345000
E upper_auipc 10 0000103c
E upper_auipc_neg 11 fffff040
E x0_read_after_x0_write 15 00000005
E unsup_no_write 16 00000000
E unsup_jal_no_link 17 00000000

//--- rv_pipe.f
verilog/rv_pipe_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_forward_unit.sv
verilog/rv_pipe.sv
verification/rv_pipe_props.sv
verification/rv_pipe_tb.sv

//--- Bender.yml
package:
  name: rv_pipe

sources:
  - verilog/rv_pipe_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_regfile.sv
  - verilog/rv_alu.sv
  - verilog/rv_forward_unit.sv
  - verilog/rv_pipe.sv
  - target: simulation
    files:
      - verification/rv_pipe_props.sv
      - verification/rv_pipe_tb.sv
